// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --assert --timescale 1ns/1ps -j 0
TOP       = vgaDemo_tb
FILELIST  = vgaDemo.f
MDIR      = obj_dir
BIN       = $(MDIR)/V$(TOP)
PASS      = Test completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(MDIR) -f $(FILELIST)

# Fails unless the pass line shows up in the output
run: compile
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS)"

clean:
	rm -rf $(MDIR)

// File: bench/vgaDemo_assertions.sv
`timescale 1ns/1ps
`include "draw_settings.svh"

module vgaDemo_assertions
	import drawPkg::*;
#(
	parameter int CountBits = $clog2(`FIFO_DEPTH) + 1
)
(
	input logic                 clk,
	input logic                 reset,
	input logic                 pixelStrobe,
	input logic                 active,
	input rgbPixel              color,
	input logic                 hsync,
	input logic [CountBits-1:0] count
);

	// Strobes with hsync low since it last went high
	int lowStrobes;

	always_ff @(posedge clk)
	begin
		if (reset)
			lowStrobes <= 0;
		else if (pixelStrobe)
			lowStrobes <= hsync ? 0 : lowStrobes + 1;
	end

	// Black outside the visible area
	blankColor: assert property (@(posedge clk) disable iff (reset)
		!active |-> (color == '0))
		else $error("color is not black while the active flag is low");

	// Sync pulse width, checked as it ends
	syncWidth: assert property (@(posedge clk) disable iff (reset)
		$rose(hsync) |-> (lowStrobes == `H_SYNC))
		else $error("hsync low for %0d strobes instead of %0d", lowStrobes, `H_SYNC);

	fifoBound: assert property (@(posedge clk) disable iff (reset)
		count <= CountBits'(`FIFO_DEPTH))
		else $error("command FIFO count %0d is past its depth", count);

endmodule

// Scanout side with the visible area rebuilt from the delayed x and y
// FIFO count port tied off
bind vgaScanout vgaDemo_assertions scanChecks (
	.clk         (clk),
	.reset       (reset),
	.pixelStrobe (pixelStrobe),
	.active      ((outPos.x < 10'(`H_ACTIVE)) && (outPos.y < 10'(`V_ACTIVE))),
	.color       (color),
	.hsync       (hsync),
	.count       ('0)
);

// FIFO side, scanout ports tied off
bind cmdFifo vgaDemo_assertions fifoChecks (
	.clk         (clk),
	.reset       (reset),
	.pixelStrobe (1'b0),
	.active      (1'b1),
	.color       ('0),
	.hsync       (1'b1),
	.count       (count)
);

// File: bench/vgaDemo_tb.sv
`timescale 1ns/1ps
`include "draw_settings.svh"

module vgaDemo_tb
	import drawPkg::*;
();

	localparam int HTotal = `H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK;
	localparam int VTotal = `V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK;
	// Two clocks per pixel
	localparam int LineClocks = 2 * HTotal;
	localparam int FrameClocks = LineClocks * VTotal;
	// First line with vsync low
	localparam int VSyncLine = `V_ACTIVE + `V_FRONT;
	// Lines from the vsync fall to the top of the next frame
	localparam int LeadLines = VTotal - VSyncLine;
	// Clocks from an hsync fall to pixel 0 of the next line
	localparam int HsToLine = 2 * (HTotal - `H_ACTIVE - `H_FRONT);
	localparam int RandomLines = 8;
	// Three frames and some spare lines, in ns
	localparam realtime WatchdogNs = (3.0 * FrameClocks + 50.0 * LineClocks) * 10.0;

	logic clk;
	logic reset;
	rgbPixel color;
	logic hsync;
	logic vsync;
	int errorCount = 0;
	int checkCount = 0;

	vgaDemo u_dut (
		.clk   (clk),
		.reset (reset),
		.color (color),
		.hsync (hsync),
		.vsync (vsync)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	////////////////////////////////////////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////////////////////////////////////////

	task automatic checkPixel(input string name, input rgbPixel got,
		input rgbPixel expected, inout int errs);
		checkCount++;
		if (got !== expected)
		begin
			errs++;
			errorCount++;
			$display("MISMATCH at %0t: %s got %b expected %b",
				$time, name, got, expected);
		end
	endtask

	task automatic checkBit(input string name, input logic got,
		input logic expected, inout int errs);
		checkCount++;
		if (got !== expected)
		begin
			errs++;
			errorCount++;
			$display("MISMATCH at %0t: %s got %b expected %b",
				$time, name, got, expected);
		end
	endtask

	// Interval lengths in clocks
	task automatic checkCycles(input string name, input int got,
		input int expected, inout int errs);
		checkCount++;
		if (got != expected)
		begin
			errs++;
			errorCount++;
			$display("MISMATCH at %0t: %s got %0d expected %0d",
				$time, name, got, expected);
		end
	endtask

	task automatic reportTest(input string name, input int errs);
		$display("%-16s %s, %0d errors", name, (errs == 0) ? "passed" : "FAILED", errs);
	endtask

	// Fall to fall period and low width of one sync, sampled mid-cycle
	task automatic measurePulse(input bit vertical, output int period, output int lowLen);
		logic prev;
		logic cur;
		int n;
		int falls;
		prev = 1'b0;
		n = 0;
		falls = 0;
		period = 0;
		lowLen = 0;
		while (falls < 2)
		begin
			@(negedge clk);
			cur = vertical ? vsync : hsync;
			if (falls > 0)
				n++;
			if (prev && !cur)
			begin
				falls++;
				if (falls == 2)
					period = n;
			end
			else if ((falls == 1) && cur && (lowLen == 0))
				lowLen = n;
			prev = cur;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////////////////////////////////////////

	task automatic resetLevels();
		int errs;
		int i;
		errs = 0;
		for (i = 0; i < 20; i++)
		begin
			@(negedge clk);
			// Syncs idle high long after the first strobe
			checkBit("hsync", hsync, 1'b1, errs);
			checkBit("vsync", vsync, 1'b1, errs);
			// Still blanked until the first strobe loads a position
			if (i < 2)
				checkPixel("color", color, '0, errs);
		end
		reportTest("reset levels", errs);
	endtask

	task automatic horizontalTiming();
		int errs;
		int period;
		int lowLen;
		errs = 0;
		measurePulse(1'b0, period, lowLen);
		checkCycles("hsync period", period, LineClocks, errs);
		checkCycles("hsync low width", lowLen, 2 * `H_SYNC, errs);
		reportTest("hsync timing", errs);
	endtask

	task automatic verticalTiming();
		int errs;
		int period;
		int lowLen;
		errs = 0;
		measurePulse(1'b1, period, lowLen);
		checkCycles("vsync period", period, FrameClocks, errs);
		checkCycles("vsync low width", lowLen, `V_SYNC * LineClocks, errs);
		reportTest("vsync timing", errs);
	endtask

	task automatic blankingLevels();
		int errs;
		int n;
		int s;
		int x;
		int y;
		errs = 0;
		@(negedge vsync);
		// From line 490 of the first frame through the whole second one
		for (n = 0; n < LeadLines * LineClocks + FrameClocks; n++)
		begin
			@(negedge clk);
			s = (VSyncLine * HTotal + n / 2) % (HTotal * VTotal);
			x = s % HTotal;
			y = s / HTotal;
			if ((x >= `H_ACTIVE) || (y >= `V_ACTIVE))
				checkPixel($sformatf("color x=%0d y=%0d", x, y), color, '0, errs);
			// One bad pixel is enough
			if (errs != 0)
				break;
		end
		reportTest("blanking", errs);
	endtask

	task automatic imageContent();
		bit pick [`V_ACTIVE];
		int midErrs;
		int edgeErrs;
		int line;
		int k;
		rgbPixel expected;
		midErrs = 0;
		edgeErrs = 0;
		pick[0] = 1'b1;
		pick[`V_ACTIVE - 1] = 1'b1;
		for (k = 0; k < RandomLines; k++)
			pick[$urandom_range(`V_ACTIVE - 1)] = 1'b1;
		@(negedge vsync);
		// Skip the hsync falls of lines 490 to 523
		repeat (LeadLines - 1) @(negedge hsync);
		for (line = 0; line < `V_ACTIVE; line++)
		begin
			// Fall in the line above, line 524 for the top line
			@(negedge hsync);
			if (pick[line])
			begin
				// Row r is drawn twice, both times in colour r mod 8
				expected = rgbPixel'(3'((line / `PIXEL_SCALE) % 8));
				repeat (HsToLine) @(posedge clk);
				@(negedge clk);
				checkPixel($sformatf("color y=%0d x=0", line), color, expected, edgeErrs);
				repeat (`H_ACTIVE) @(posedge clk);
				@(negedge clk);
				checkPixel($sformatf("color y=%0d x=320", line), color, expected, midErrs);
				repeat (`H_ACTIVE - 2) @(posedge clk);
				@(negedge clk);
				checkPixel($sformatf("color y=%0d x=639", line), color, expected, edgeErrs);
			end
		end
		reportTest("image content", midErrs);
		reportTest("full width", edgeErrs);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Sequence and watchdog
	////////////////////////////////////////////////////////////////////////////

	initial
	begin
		void'($urandom(81431));
		reset = 1'b1;
		repeat (3) @(posedge clk);
		reset <= 1'b0;
		resetLevels();
		horizontalTiming();
		// The frame tests all watch the second frame
		fork
			verticalTiming();
			blankingLevels();
			imageContent();
		join
		$display("Checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

	initial
	begin
		#(WatchdogNs);
		$display("Timeout: the tests were still running at %0t", $time);
		$display("Test failed");
		$finish;
	end

endmodule

// File: design/cmdFifo.sv
`timescale 1ns/1ps
`include "draw_settings.svh"

module cmdFifo
	import drawPkg::*;
(
	input  logic   clk,
	input  logic   reset,
	input  logic   wr,
	input  cmdWord wrData,
	input  logic   rd,
	output cmdWord rdData,
	output logic   full,
	output logic   empty
);

	localparam int PtrBits = $clog2(`FIFO_DEPTH);
	localparam logic [PtrBits:0] DepthCount = (PtrBits + 1)'(`FIFO_DEPTH);

	cmdWord mem [`FIFO_DEPTH];
	logic [PtrBits-1:0] wrPtr;
	logic [PtrBits-1:0] rdPtr;
	logic [PtrBits:0] count;
	logic doWrite;
	logic doRead;

	// Writes into a full queue are dropped
	assign doWrite = wr && !full;
	assign doRead = rd && !empty;

	assign full = (count == DepthCount);
	assign empty = (count == '0);

	// Head word visible without a clock
	assign rdData = mem[rdPtr];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			// Pointers wrap naturally
			if (doWrite)
				wrPtr <= wrPtr + 1'b1;
			if (doRead)
				rdPtr <= rdPtr + 1'b1;
			case ({doWrite, doRead})
				2'b10:
					count <= count + 1'b1;
				2'b01:
					count <= count - 1'b1;
				default:
					count <= count;
			endcase
		end
	end

	// Storage
	always_ff @(posedge clk)
	begin
		if (doWrite)
			mem[wrPtr] <= wrData;
	end

endmodule

// File: design/drawPkg.sv
package drawPkg;

	// One stored pixel, ordered {R, G, B}
	typedef struct packed
	{
		logic red;
		logic green;
		logic blue;
	} rgbPixel;

	// Head word opcodes in bits 15:14
	typedef enum logic [1:0]
	{
		SPAN  = 2'b00,
		CLEAR = 2'b11
	} cmdOpcode;

	// Command word as it travels through the FIFO
	// Low byte of a SPAN tail word is the end column
	typedef struct packed
	{
		cmdOpcode   opcode;
		logic [3:0] unused;
		rgbPixel    color;
		logic [6:0] row;
	} cmdWord;

	// Linear buffer address, row * 160 + column
	typedef logic [14:0] fbAddr;

	// Write port bundle from the rasterizer
	typedef struct packed
	{
		logic    en;
		fbAddr   addr;
		rgbPixel pixel;
	} fbWrite;

	// Raster position with its sync and blanking levels
	typedef struct packed
	{
		logic       hsync;
		logic       vsync;
		logic       active;
		logic [9:0] x;
		logic [9:0] y;
	} scanPos;

	typedef enum logic [1:0]
	{
		IDLE,
		FETCH_TAIL,
		FILL,
		CLEARING
	} rasterState;

	typedef enum logic [1:0]
	{
		SEND_CLEAR,
		SEND_HEAD,
		SEND_TAIL,
		DONE
	} sourceState;

endpackage

// File: design/drawUnit.sv
`timescale 1ns/1ps

module drawUnit
	import drawPkg::*;
(
	input  logic    clk,
	input  logic    reset,
	input  logic    we,
	input  cmdWord  dataIn,
	output logic    full,
	output rgbPixel color,
	output logic    hsync,
	output logic    vsync
);

	logic pixelStrobe;
	logic fifoRd;
	logic fifoEmpty;
	cmdWord fifoData;
	fbWrite fbWr;
	fbAddr readAddr;
	rgbPixel readPixel;

	// Pixel rate is half of clk
	always_ff @(posedge clk)
	begin
		if (reset)
			pixelStrobe <= 1'b0;
		else
			pixelStrobe <= ~pixelStrobe;
	end

	cmdFifo cmdQueue (
		.clk    (clk),
		.reset  (reset),
		.wr     (we),
		.wrData (dataIn),
		.rd     (fifoRd),
		.rdData (fifoData),
		.full   (full),
		.empty  (fifoEmpty)
	);

	spanRasterizer rasterizer (
		.clk    (clk),
		.reset  (reset),
		.rdData (fifoData),
		.empty  (fifoEmpty),
		.rd     (fifoRd),
		.fbWr   (fbWr)
	);

	frameBuffer frame (
		.clk       (clk),
		.fbWr      (fbWr),
		.readAddr  (readAddr),
		.readPixel (readPixel)
	);

	vgaScanout scanout (
		.clk         (clk),
		.reset       (reset),
		.pixelStrobe (pixelStrobe),
		.readAddr    (readAddr),
		.readPixel   (readPixel),
		.color       (color),
		.hsync       (hsync),
		.vsync       (vsync)
	);

endmodule

// File: design/draw_settings.svh
`ifndef DRAW_SETTINGS_SVH
`define DRAW_SETTINGS_SVH

////////////////////////////////////////////////////////////////////////////
// Frame buffer geometry
////////////////////////////////////////////////////////////////////////////

// Stored columns and rows
`define FB_WIDTH    160
`define FB_HEIGHT   120

// Screen block side per stored pixel
`define PIXEL_SCALE 4

// Command FIFO words, power of two
`define FIFO_DEPTH  16

////////////////////////////////////////////////////////////////////////////
// VGA 640x480 timing
////////////////////////////////////////////////////////////////////////////

// Horizontal, in pixels
`define H_ACTIVE    640
`define H_FRONT     16
`define H_SYNC      96
`define H_BACK      48

// Vertical, in lines
`define V_ACTIVE    480
`define V_FRONT     10
`define V_SYNC      2
`define V_BACK      33

`endif

// File: design/frameBuffer.sv
`timescale 1ns/1ps
`include "draw_settings.svh"

module frameBuffer
	import drawPkg::*;
(
	input  logic    clk,
	input  fbWrite  fbWr,
	input  fbAddr   readAddr,
	output rgbPixel readPixel
);

	localparam int Depth = `FB_WIDTH * `FB_HEIGHT;

	// One entry per stored pixel, 160 x 120
	rgbPixel mem [Depth];

	// Rasterizer side
	always_ff @(posedge clk)
	begin
		if (fbWr.en)
			mem[fbWr.addr] <= fbWr.pixel;
	end

	// Scanout side, data one clock after address
	always_ff @(posedge clk)
	begin
		readPixel <= mem[readAddr];
	end

endmodule

// File: design/patternSource.sv
`timescale 1ns/1ps
`include "draw_settings.svh"

module patternSource
	import drawPkg::*;
(
	input  logic   clk,
	input  logic   reset,
	input  logic   full,
	output logic   we,
	output cmdWord dataIn
);

	localparam logic [7:0] SpanCount = 8'(2 * `FB_HEIGHT);
	localparam logic [7:0] RowCount = 8'(`FB_HEIGHT);

	sourceState state;
	sourceState nextState;
	logic [7:0] spanIndex;
	logic [7:0] rowIndex;
	logic send;
	cmdWord nextWord;

	// Second pass reuses the rows
	assign rowIndex = (spanIndex >= RowCount) ? spanIndex - RowCount : spanIndex;

	// A new word only after the last one went in, and only with room left
	always_comb
	begin
		nextState = state;
		nextWord = '0;
		send = 1'b0;
		if (!we && !full)
		begin
			case (state)
				SEND_CLEAR:
				begin
					nextWord = '{opcode: CLEAR, unused: '0, color: '0, row: '0};
					send = 1'b1;
					nextState = SEND_HEAD;
				end
				SEND_HEAD:
					if (spanIndex == SpanCount)
						nextState = DONE;
					else
					begin
						// Stripe colour cycles through all eight
						nextWord = '{opcode: SPAN, unused: '0,
							color: rgbPixel'(spanIndex[2:0]), row: rowIndex[6:0]};
						send = 1'b1;
						nextState = SEND_TAIL;
					end
				SEND_TAIL:
				begin
					// Full-width span
					nextWord = cmdWord'(16'(`FB_WIDTH - 1));
					send = 1'b1;
					nextState = SEND_HEAD;
				end
				default:
					nextState = DONE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= SEND_CLEAR;
			we <= 1'b0;
			spanIndex <= '0;
		end
		else
		begin
			state <= nextState;
			we <= send;
			if ((state == SEND_TAIL) && send)
				spanIndex <= spanIndex + 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (send)
			dataIn <= nextWord;
	end

endmodule

// File: design/spanRasterizer.sv
`timescale 1ns/1ps
`include "draw_settings.svh"

module spanRasterizer
	import drawPkg::*;
(
	input  logic   clk,
	input  logic   reset,
	input  cmdWord rdData,
	input  logic   empty,
	output logic   rd,
	output fbWrite fbWr
);

	localparam fbAddr LastAddr = fbAddr'(`FB_WIDTH * `FB_HEIGHT - 1);
	localparam logic [7:0] LastCol = 8'(`FB_WIDTH - 1);
	localparam logic [6:0] RowLimit = 7'(`FB_HEIGHT);

	rasterState state;
	rasterState nextState;
	logic [6:0] spanRow;
	rgbPixel spanColor;
	logic [7:0] tailEnd;
	logic [7:0] endCol;
	logic [7:0] col;
	fbAddr writeAddr;

	// End column sits in the low byte of the tail word
	assign tailEnd = rdData[7:0];

	// Pop only while waiting for a head or a tail
	assign rd = !empty && ((state == IDLE) || (state == FETCH_TAIL));

	// One pixel per cycle in FILL and CLEARING
	always_comb
	begin
		fbWr.en = (state == FILL) || (state == CLEARING);
		fbWr.addr = writeAddr;
		fbWr.pixel = (state == FILL) ? spanColor : '0;
	end

	////////////////////////////////////////////////////////////////////////////
	// Command FSM
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		nextState = state;
		case (state)
			IDLE:
				if (!empty)
				begin
					// Unknown opcodes are popped and dropped
					if (rdData.opcode == CLEAR)
						nextState = CLEARING;
					else if (rdData.opcode == SPAN)
						nextState = FETCH_TAIL;
				end
			FETCH_TAIL:
				if (!empty)
				begin
					// Rows past the bottom draw nothing
					nextState = (spanRow < RowLimit) ? FILL : IDLE;
				end
			FILL:
				if (col == endCol)
					nextState = IDLE;
			CLEARING:
				if (writeAddr == LastAddr)
					nextState = IDLE;
			default:
				nextState = IDLE;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			state <= IDLE;
		else
			state <= nextState;
	end

	////////////////////////////////////////////////////////////////////////////
	// Span registers and write address
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		case (state)
			IDLE:
			begin
				// Head fields, kept from the popped word
				spanRow <= rdData.row;
				spanColor <= rdData.color;
				writeAddr <= '0;
			end
			FETCH_TAIL:
			begin
				// Clip to the last column
				endCol <= (tailEnd > LastCol) ? LastCol : tailEnd;
				col <= '0;
				writeAddr <= fbAddr'(spanRow) * fbAddr'(`FB_WIDTH);
			end
			default:
			begin
				col <= col + 1'b1;
				writeAddr <= writeAddr + 1'b1;
			end
		endcase
	end

endmodule

// File: design/vgaDemo.sv
`timescale 1ns/1ps

module vgaDemo
	import drawPkg::*;
(
	input  logic    clk,
	input  logic    reset,
	output rgbPixel color,
	output logic    hsync,
	output logic    vsync
);

	logic we;
	logic full;
	cmdWord dataIn;

	patternSource source (
		.clk    (clk),
		.reset  (reset),
		.full   (full),
		.we     (we),
		.dataIn (dataIn)
	);

	drawUnit draw (
		.clk    (clk),
		.reset  (reset),
		.we     (we),
		.dataIn (dataIn),
		.full   (full),
		.color  (color),
		.hsync  (hsync),
		.vsync  (vsync)
	);

endmodule

// File: design/vgaScanout.sv
`timescale 1ns/1ps
`include "draw_settings.svh"

module vgaScanout
	import drawPkg::*;
(
	input  logic    clk,
	input  logic    reset,
	input  logic    pixelStrobe,
	output fbAddr   readAddr,
	input  rgbPixel readPixel,
	output rgbPixel color,
	output logic    hsync,
	output logic    vsync
);

	localparam logic [9:0] HLast = 10'(`H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK - 1);
	localparam logic [9:0] VLast = 10'(`V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK - 1);
	localparam logic [9:0] HSyncStart = 10'(`H_ACTIVE + `H_FRONT);
	localparam logic [9:0] HSyncEnd = 10'(`H_ACTIVE + `H_FRONT + `H_SYNC);
	localparam logic [9:0] VSyncStart = 10'(`V_ACTIVE + `V_FRONT);
	localparam logic [9:0] VSyncEnd = 10'(`V_ACTIVE + `V_FRONT + `V_SYNC);
	localparam logic [9:0] Scale = 10'(`PIXEL_SCALE);

	logic [9:0] hCount;
	logic [9:0] vCount;
	logic [9:0] cellX;
	logic [9:0] cellY;
	scanPos pos;
	scanPos outPos;
	rgbPixel pixelReg;

	// Raster counters, one step per strobe
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			hCount <= '0;
			vCount <= '0;
		end
		else if (pixelStrobe)
		begin
			if (hCount == HLast)
			begin
				hCount <= '0;
				if (vCount == VLast)
					vCount <= '0;
				else
					vCount <= vCount + 1'b1;
			end
			else
				hCount <= hCount + 1'b1;
		end
	end

	// Both syncs active low
	always_comb
	begin
		pos.x = hCount;
		pos.y = vCount;
		pos.active = (hCount < 10'(`H_ACTIVE)) && (vCount < 10'(`V_ACTIVE));
		pos.hsync = !((hCount >= HSyncStart) && (hCount < HSyncEnd));
		pos.vsync = !((vCount >= VSyncStart) && (vCount < VSyncEnd));
	end

	// Each stored pixel covers a 4 x 4 screen block
	assign cellX = pos.x / Scale;
	assign cellY = pos.y / Scale;
	// Parked at zero in blanking so the read stays in range
	assign readAddr = pos.active ? fbAddr'(cellY) * fbAddr'(`FB_WIDTH) + fbAddr'(cellX) : '0;

	// Position held back one strobe to meet the registered read
	always_ff @(posedge clk)
	begin
		if (reset)
			outPos <= '{hsync: 1'b1, vsync: 1'b1, active: 1'b0, x: '0, y: '0};
		else if (pixelStrobe)
			outPos <= pos;
	end

	always_ff @(posedge clk)
	begin
		if (pixelStrobe)
			pixelReg <= readPixel;
	end

	// Black outside the visible area
	assign color = outPos.active ? pixelReg : '0;
	assign hsync = outPos.hsync;
	assign vsync = outPos.vsync;

endmodule

// File: vgaDemo.f
+incdir+design
design/drawPkg.sv
design/cmdFifo.sv
design/frameBuffer.sv
design/spanRasterizer.sv
design/vgaScanout.sv
design/drawUnit.sv
design/patternSource.sv
design/vgaDemo.sv
bench/vgaDemo_assertions.sv
bench/vgaDemo_tb.sv
